// ==== sb2_main_bus.f ====
sb2_main_bus_pkg.sv
sb2_dev_if.sv
sb2_axi_frontend.sv
sb2_work_ram.sv
sb2_cabinet_io.sv
sb2_main_bus.sv
sb2_main_bus_properties.sv
tb_sb2_main_bus.sv

// ==== Makefile ====
# Verilator lint and simulation for the sb2 main bus testbench

VERILATOR ?= verilator
TOP       ?= tb_sb2_main_bus
FILELIST  ?= sb2_main_bus.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_sb2_main_bus.sv ====
// main bus testbench with AXI driver tasks, memory and port models, compare tasks
// covers RAM, palette video port, cabinet ports, OKI latch, DECERR, back-pressure
`timescale 1ns/1ps
`default_nettype none

module tb_sb2_main_bus;

    localparam int AW  = sb2_main_bus_pkg::ADDR_W;
    localparam int DW  = sb2_main_bus_pkg::DATA_W;
    localparam int SW  = sb2_main_bus_pkg::STRB_W;
    localparam int TMO = 64;  // cycles allowed per wait

    logic          CLK96;
    logic          RESET96;
    logic [AW-1:0] s_axi_awaddr;
    logic [AW-1:0] s_axi_araddr;
    logic [DW-1:0] s_axi_wdata;
    logic [DW-1:0] s_axi_rdata;
    logic [SW-1:0] s_axi_wstrb;
    logic [1:0]    s_axi_bresp;
    logic [1:0]    s_axi_rresp;
    logic          s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
    logic          s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
    logic          s_axi_rvalid, s_axi_rready;
    logic [9:0]    joystick1, joystick2;
    logic [1:0]    start_button, coin_input;
    logic          service, dip_test, oki_bank;
    logic [7:0]    dipsw_a, dipsw_b, dipsw_c;
    logic [10:0]   pal_addr;
    logic [15:0]   pal_data;
    logic [DW-1:0] mem_model [int];  // keyed by byte address / 4

    sb2_main_bus dut0 (.*);

    bind sb2_axi_frontend sb2_main_bus_properties props0 (
        .clk96(clk96), .reset96(reset96),
        .bvalid(s_axi_bvalid), .bready(s_axi_bready), .bresp(s_axi_bresp),
        .rvalid(s_axi_rvalid), .rready(s_axi_rready), .rdata(s_axi_rdata),
        .rresp(s_axi_rresp), .ram_req(ram.req), .io_req(io.req)
    );

    always #10 CLK96 = ~CLK96;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp,
                              input logic [1:0] act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_pal(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    endtask

    function automatic void model_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                                        input logic [SW-1:0] strb);
        logic [DW-1:0] w;
        int k;
        k = int'(addr[AW-1:2]);
        w = mem_model.exists(k) ? mem_model[k] : '0;
        for (int b = 0; b < SW; b++)
            if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
        mem_model[k] = w;
    endfunction

    function automatic logic [DW-1:0] model_read(input logic [AW-1:0] addr);
        return mem_model[int'(addr[AW-1:2])];
    endfunction

    // entry index to half of a palette word
    function automatic logic [15:0] pal_model(input logic [10:0] entry);
        logic [DW-1:0] w;
        w = model_read({sb2_main_bus_pkg::REGION_PALRAM, 8'h00, entry[10:1], 2'b00});
        return entry[0] ? w[31:16] : w[15:0];
    endfunction

    function automatic logic [7:0] joy_port(input logic [9:0] j);
        logic [7:0] p;
        p = 8'h00;
        p[5] = !j[5];
        p[4] = !j[4];
        p[3] = !j[0];
        p[2] = !j[1];
        p[1] = !j[2];
        p[0] = !j[3];
        return p;
    endfunction

    function automatic logic [15:0] exp_port_word(input logic [19:0] off);
        logic [7:0] sys;
        sys    = 8'h00;
        sys[6] = !start_button[1];
        sys[5] = !start_button[0];
        sys[4] = !coin_input[1];
        sys[3] = !coin_input[0];
        sys[2] = !dip_test;
        sys[0] = !service;
        case (off)
            sb2_main_bus_pkg::PORT_IN1:  return {joy_port(joystick1), joy_port(joystick1)};
            sb2_main_bus_pkg::PORT_IN2:  return {joy_port(joystick2), joy_port(joystick2)};
            sb2_main_bus_pkg::PORT_SYS:  return {dipsw_c, sys};
            sb2_main_bus_pkg::PORT_DSWA: return {dipsw_a, dipsw_a};
            sb2_main_bus_pkg::PORT_DSWB: return {dipsw_b, dipsw_b};
            sb2_main_bus_pkg::PORT_JMPR: return {dipsw_c, dipsw_c};
            default:                     return 16'h0000;
        endcase
    endfunction

    // entered and left 2 ns after a rising edge
    task automatic axi_read(input logic [AW-1:0] addr, input int stall,
                            output logic [DW-1:0] data, output logic [1:0] resp);
        int n;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        n = 0;
        @(negedge CLK96);
        while (!s_axi_arready) begin
            n++;
            if (n > TMO) abort_run("timeout: read address never accepted");
            @(negedge CLK96);
        end
        @(posedge CLK96);
        #2 s_axi_arvalid = 1'b0;
        n = 0;
        while (!s_axi_rvalid) begin
            n++;
            if (n > TMO) abort_run("timeout: read response never arrived");
            @(negedge CLK96);
        end
        data = s_axi_rdata;
        resp = s_axi_rresp;
        repeat (stall) begin
            @(negedge CLK96);
            check_bit("rvalid held", 1'b1, s_axi_rvalid);
            check_data("rdata held", data, s_axi_rdata);
            check_resp("rresp held", resp, s_axi_rresp);
        end
        @(posedge CLK96);
        #2 s_axi_rready = 1'b1;
        @(posedge CLK96);
        #2 s_axi_rready = 1'b0;
    endtask

    task automatic axi_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                             input logic [SW-1:0] strb, input int stall, output logic [1:0] resp);
        int n;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        n = 0;
        @(negedge CLK96);
        while (!(s_axi_awready && s_axi_wready)) begin
            n++;
            if (n > TMO) abort_run("timeout: write address and data never accepted");
            @(negedge CLK96);
        end
        @(posedge CLK96);
        #2 s_axi_awvalid = 1'b0;
        s_axi_wvalid = 1'b0;
        n = 0;
        while (!s_axi_bvalid) begin
            n++;
            if (n > TMO) abort_run("timeout: write response never arrived");
            @(negedge CLK96);
        end
        resp = s_axi_bresp;
        repeat (stall) begin
            @(negedge CLK96);
            check_bit("bvalid held", 1'b1, s_axi_bvalid);
            check_resp("bresp held", resp, s_axi_bresp);
        end
        @(posedge CLK96);
        #2 s_axi_bready = 1'b1;
        @(posedge CLK96);
        #2 s_axi_bready = 1'b0;
    endtask

    task automatic shuffle_cabinet;
        joystick1    = 10'($urandom);
        joystick2    = 10'($urandom);
        start_button = 2'($urandom);
        coin_input   = 2'($urandom);
        service      = 1'($urandom);
        dip_test     = 1'($urandom);
        dipsw_a      = 8'($urandom);
        dipsw_b      = 8'($urandom);
        dipsw_c      = 8'($urandom);
    endtask

    initial begin
        logic [DW-1:0] d;
        logic [DW-1:0] wd;
        logic [1:0]    r;
        logic [AW-1:0] a;
        logic [SW-1:0] st;
        logic [AW-1:0] addrs [$];
        logic [19:0]   offs [$];
        void'($urandom(98155));
        CLK96 = 1'b0;
        RESET96 = 1'b1;
        {s_axi_awaddr, s_axi_araddr, s_axi_wdata, s_axi_wstrb} = '0;
        {s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready} = '0;
        {joystick1, joystick2, start_button, coin_input, service, dip_test} = '0;
        {dipsw_a, dipsw_b, dipsw_c, pal_addr} = '0;
        repeat (2) @(posedge CLK96);
        #2 RESET96 = 1'b0;
        check_bit("reset bvalid", 1'b0, s_axi_bvalid);
        check_bit("reset rvalid", 1'b0, s_axi_rvalid);
        check_bit("reset oki_bank", 1'b0, oki_bank);

        // work RAM full word first then a random strobe over it
        for (int i = 0; i < 16; i++) begin
            a  = {sb2_main_bus_pkg::REGION_WRAM, 20'($urandom) & 20'h0FFFC};
            wd = $urandom;
            axi_write(a, wd, 4'hF, 0, r);
            check_resp("wram fill resp", sb2_main_bus_pkg::RESP_OKAY, r);
            model_write(a, wd, 4'hF);
            wd = $urandom;
            st = 4'($urandom);
            axi_write(a, wd, st, 0, r);
            check_resp("wram write resp", sb2_main_bus_pkg::RESP_OKAY, r);
            model_write(a, wd, st);
            addrs.push_back(a);
        end
        foreach (addrs[i]) begin
            axi_read(addrs[i], 0, d, r);
            check_data("wram read", model_read(addrs[i]), d);
            check_resp("wram read resp", sb2_main_bus_pkg::RESP_OKAY, r);
        end

        // palette over AXI and then the video port
        for (int i = 0; i < 16; i++) begin
            a  = {sb2_main_bus_pkg::REGION_PALRAM, 20'(i * 4)};
            wd = $urandom;
            axi_write(a, wd, 4'hF, 0, r);
            model_write(a, wd, 4'hF);
        end
        for (int e = 0; e < 32; e++) begin
            pal_addr = 11'(e);
            @(negedge CLK96);
            if (e > 0)
                check_pal("pal video hold", pal_model(11'(e - 1)), pal_data);
            @(posedge CLK96);
            #2 check_pal("pal video", pal_model(11'(e)), pal_data);
        end
        for (int i = 0; i < 16; i++) begin
            a = {sb2_main_bus_pkg::REGION_PALRAM, 20'(i * 4)};
            axi_read(a, 0, d, r);
            check_data("pal read", model_read(a), d);
            check_resp("pal read resp", sb2_main_bus_pkg::RESP_OKAY, r);
        end

        // cabinet ports plus the unused offset 0x14
        offs = '{sb2_main_bus_pkg::PORT_JMPR, sb2_main_bus_pkg::PORT_DSWA,
                 sb2_main_bus_pkg::PORT_DSWB, sb2_main_bus_pkg::PORT_IN1,
                 sb2_main_bus_pkg::PORT_IN2, sb2_main_bus_pkg::PORT_SYS, 20'h00014};
        repeat (4) begin
            shuffle_cabinet();
            foreach (offs[k]) begin
                axi_read({sb2_main_bus_pkg::REGION_IO, offs[k]}, 0, d, r);
                check_data("io port", {16'h0000, exp_port_word(offs[k])}, d);
                check_resp("io port resp", sb2_main_bus_pkg::RESP_OKAY, r);
            end
        end

        axi_write(24'h500000, 32'h0000_0010, 4'hF, 0, r);
        check_resp("oki set resp", sb2_main_bus_pkg::RESP_OKAY, r);
        check_bit("oki set", 1'b1, oki_bank);
        axi_write(24'h500000, 32'hFFFF_FFEF, 4'hF, 0, r);
        check_resp("oki clear resp", sb2_main_bus_pkg::RESP_OKAY, r);
        check_bit("oki clear", 1'b0, oki_bank);

        axi_read(24'h200000, 0, d, r);
        check_resp("unmapped read resp", sb2_main_bus_pkg::RESP_DECERR, r);
        check_data("unmapped read data", '0, d);
        axi_write(24'h200010, 32'h1234_5678, 4'hF, 0, r);
        check_resp("unmapped write resp", sb2_main_bus_pkg::RESP_DECERR, r);

        // responses held under random back-pressure
        a = addrs[0];
        wd = $urandom;
        axi_write(a, wd, 4'hF, 1 + int'($urandom % 8), r);
        model_write(a, wd, 4'hF);
        check_resp("stalled write resp", sb2_main_bus_pkg::RESP_OKAY, r);
        axi_read(a, 1 + int'($urandom % 8), d, r);
        check_data("stalled read", model_read(a), d);
        axi_read(24'h300000, 1 + int'($urandom % 8), d, r);
        check_resp("stalled decerr", sb2_main_bus_pkg::RESP_DECERR, r);
        check_data("stalled decerr data", '0, d);
        axi_read(addrs[1], 0, d, r);
        check_data("read after stall", model_read(addrs[1]), d);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sb2_main_bus_properties.sv ====
// concurrent checks on the AXI front end handshakes
// response hold under back-pressure, exclusive device requests, reset state
`timescale 1ns/1ps
`default_nettype none

module sb2_main_bus_properties (
    input wire logic                                clk96,
    input wire logic                                reset96,
    input wire logic                                bvalid,
    input wire logic                                bready,
    input wire logic [1:0]                          bresp,
    input wire logic                                rvalid,
    input wire logic                                rready,
    input wire logic [sb2_main_bus_pkg::DATA_W-1:0] rdata,
    input wire logic [1:0]                          rresp,
    input wire logic                                ram_req,
    input wire logic                                io_req
);

    assert property (@(posedge clk96) disable iff (reset96)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response dropped or changed before bready");

    // read data and response held too
    assert property (@(posedge clk96) disable iff (reset96)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("read response dropped or changed before rready");

    assert property (@(posedge clk96) disable iff (reset96) !(ram_req && io_req))
        else $error("ram and io requests issued together");

    assert property (@(posedge clk96) reset96 |=> !bvalid && !rvalid)
        else $error("response valid high during reset");

endmodule

`default_nettype wire

// ==== sb2_main_bus.sv ====
// main CPU memory map top level
// AXI front end, work/palette RAM and cabinet I/O on two device links
`timescale 1ns/1ps
`default_nettype none

module sb2_main_bus #(
    parameter int WRAM_AW = 14,
    parameter int PAL_AW  = 10
) (
    input  wire logic                                CLK96,
    input  wire logic                                RESET96,

    input  wire logic [sb2_main_bus_pkg::ADDR_W-1:0] s_axi_awaddr,
    input  wire logic                                s_axi_awvalid,
    output logic                                     s_axi_awready,
    input  wire logic [sb2_main_bus_pkg::DATA_W-1:0] s_axi_wdata,
    input  wire logic [sb2_main_bus_pkg::STRB_W-1:0] s_axi_wstrb,
    input  wire logic                                s_axi_wvalid,
    output logic                                     s_axi_wready,
    output logic [1:0]                               s_axi_bresp,
    output logic                                     s_axi_bvalid,
    input  wire logic                                s_axi_bready,
    input  wire logic [sb2_main_bus_pkg::ADDR_W-1:0] s_axi_araddr,
    input  wire logic                                s_axi_arvalid,
    output logic                                     s_axi_arready,
    output logic [sb2_main_bus_pkg::DATA_W-1:0]      s_axi_rdata,
    output logic [1:0]                               s_axi_rresp,
    output logic                                     s_axi_rvalid,
    input  wire logic                                s_axi_rready,

    input  wire logic [9:0]                          joystick1,
    input  wire logic [9:0]                          joystick2,
    input  wire logic [1:0]                          start_button,
    input  wire logic [1:0]                          coin_input,
    input  wire logic                                service,
    input  wire logic                                dip_test,
    input  wire logic [7:0]                          dipsw_a,
    input  wire logic [7:0]                          dipsw_b,
    input  wire logic [7:0]                          dipsw_c,

    output logic                                     oki_bank,

    input  wire logic [10:0]                         pal_addr,
    output logic [15:0]                              pal_data
);

    sb2_dev_if ram_bus ();
    sb2_dev_if io_bus ();

    sb2_axi_frontend u_frontend (
        .clk96         (CLK96),
        .reset96       (RESET96),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .ram           (ram_bus),
        .io            (io_bus)
    );

    sb2_work_ram #(
        .WRAM_AW (WRAM_AW),
        .PAL_AW  (PAL_AW)
    ) u_work_ram (
        .CLK96    (CLK96),
        .bus      (ram_bus),
        .pal_addr (pal_addr),
        .pal_data (pal_data)
    );

    sb2_cabinet_io u_cabinet_io (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .bus          (io_bus),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .oki_bank     (oki_bank)
    );

endmodule

`default_nettype wire

// ==== sb2_cabinet_io.sv ====
// cabinet input ports, DIP switch ports and OKI sample bank latch
`timescale 1ns/1ps
`default_nettype none

module sb2_cabinet_io (
    input  wire logic       CLK96,
    input  wire logic       RESET96,
    sb2_dev_if.device       bus,

    input  wire logic [9:0] joystick1,
    input  wire logic [9:0] joystick2,
    input  wire logic [1:0] start_button,
    input  wire logic [1:0] coin_input,
    input  wire logic       service,
    input  wire logic       dip_test,
    input  wire logic [7:0] dipsw_a,
    input  wire logic [7:0] dipsw_b,
    input  wire logic [7:0] dipsw_c,

    output logic            oki_bank
);

    logic [7:0]  sys_lo;
    logic [15:0] port_word;
    logic        io_read;
    logic        oki_write;

    // inputs are active high here but the board expects active low
    function automatic logic [7:0] joy_byte(input logic [9:0] j);
        return {2'b00, ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
    endfunction

    assign sys_lo = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                     ~coin_input[0], ~dip_test, 1'b0, ~service};

    always_comb begin
        case (bus.offset)
            sb2_main_bus_pkg::PORT_IN1:  port_word = {2{joy_byte(joystick1)}};
            sb2_main_bus_pkg::PORT_IN2:  port_word = {2{joy_byte(joystick2)}};
            sb2_main_bus_pkg::PORT_SYS:  port_word = {dipsw_c, sys_lo};  // halves differ
            sb2_main_bus_pkg::PORT_DSWA: port_word = {2{dipsw_a}};
            sb2_main_bus_pkg::PORT_DSWB: port_word = {2{dipsw_b}};
            sb2_main_bus_pkg::PORT_JMPR: port_word = {2{dipsw_c}};  // jumpers
            default:                     port_word = 16'h0000;
        endcase
    end

    assign io_read   = bus.req && !bus.we && (bus.region == sb2_main_bus_pkg::REGION_IO);
    assign oki_write = bus.req && bus.we && (bus.region == sb2_main_bus_pkg::REGION_OKI);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            bus.ack  <= 1'b0;
            oki_bank <= 1'b0;
        end else begin
            bus.ack <= bus.req;
            if (oki_write)
                oki_bank <= bus.wdata[sb2_main_bus_pkg::OKI_BANK_BIT];
        end
    end

    // OKI reads and IO writes answer zero
    always_ff @(posedge CLK96) begin
        if (bus.req)
            bus.rdata <= io_read ? {16'h0000, port_word} : '0;
    end

endmodule

`default_nettype wire

// ==== sb2_work_ram.sv ====
// work RAM and palette RAM, 32-bit words with byte write enables
// palette has a second read-only port for the video side
`timescale 1ns/1ps
`default_nettype none

module sb2_work_ram #(
    parameter int WRAM_AW = 14,  // 64 KB work RAM
    parameter int PAL_AW  = 10   // 4 KB palette
) (
    input  wire logic        CLK96,
    sb2_dev_if.device        bus,
    input  wire logic [10:0] pal_addr,  // 16-bit entry index
    output logic [15:0]      pal_data
);

    localparam int STRB_W = sb2_main_bus_pkg::STRB_W;

    logic [sb2_main_bus_pkg::DATA_W-1:0] wram_mem [2**WRAM_AW];
    logic [sb2_main_bus_pkg::DATA_W-1:0] pal_mem  [2**PAL_AW];

    logic               sel_pal;
    logic [WRAM_AW-1:0] wram_idx;
    logic [PAL_AW-1:0]  pal_idx;
    logic [PAL_AW-1:0]  vid_idx;

    assign sel_pal  = (bus.region == sb2_main_bus_pkg::REGION_PALRAM);
    assign wram_idx = bus.offset[WRAM_AW+1:2];  // byte offset to word index
    assign pal_idx  = bus.offset[PAL_AW+1:2];
    assign vid_idx  = pal_addr[PAL_AW:1];       // two entries per word

    always_ff @(posedge CLK96) begin
        if (bus.req && bus.we) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (bus.wstrb[b]) begin
                    if (sel_pal)
                        pal_mem[pal_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                    else
                        wram_mem[wram_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // bus read data and ack one cycle after req
    always_ff @(posedge CLK96) begin
        bus.ack <= bus.req;
        if (bus.req)
            bus.rdata <= sel_pal ? pal_mem[pal_idx] : wram_mem[wram_idx];
    end

    // video read with the lower entry in bits [15:0]
    always_ff @(posedge CLK96) begin
        pal_data <= pal_addr[0] ? pal_mem[vid_idx][31:16] : pal_mem[vid_idx][15:0];
    end

endmodule

`default_nettype wire

// ==== sb2_axi_frontend.sv ====
// AXI4-Lite slave for the main CPU side
// one transaction at a time, region decode, one device request per access
`timescale 1ns/1ps
`default_nettype none

module sb2_axi_frontend (
    input  wire logic                                clk96,
    input  wire logic                                reset96,

    input  wire logic [sb2_main_bus_pkg::ADDR_W-1:0] s_axi_awaddr,
    input  wire logic                                s_axi_awvalid,
    output logic                                     s_axi_awready,
    input  wire logic [sb2_main_bus_pkg::DATA_W-1:0] s_axi_wdata,
    input  wire logic [sb2_main_bus_pkg::STRB_W-1:0] s_axi_wstrb,
    input  wire logic                                s_axi_wvalid,
    output logic                                     s_axi_wready,
    output logic [1:0]                               s_axi_bresp,
    output logic                                     s_axi_bvalid,
    input  wire logic                                s_axi_bready,
    input  wire logic [sb2_main_bus_pkg::ADDR_W-1:0] s_axi_araddr,
    input  wire logic                                s_axi_arvalid,
    output logic                                     s_axi_arready,
    output logic [sb2_main_bus_pkg::DATA_W-1:0]      s_axi_rdata,
    output logic [1:0]                               s_axi_rresp,
    output logic                                     s_axi_rvalid,
    input  wire logic                                s_axi_rready,

    sb2_dev_if.host                                  ram,
    sb2_dev_if.host                                  io
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;  // issue device request
    localparam logic [1:0] S_WAIT = 2'd2;  // wait for ack
    localparam logic [1:0] S_RESP = 2'd3;  // hold response until taken

    logic [1:0]                          state;
    sb2_main_bus_pkg::sb2_addr_u         addr_q;
    logic                                we_q;
    logic [sb2_main_bus_pkg::DATA_W-1:0] wdata_q;
    logic [sb2_main_bus_pkg::STRB_W-1:0] wstrb_q;
    logic [sb2_main_bus_pkg::DATA_W-1:0] rdata_q;
    logic [1:0]                          resp_q;
    logic                                rd_acc;
    logic                                wr_acc;
    logic                                sel_ram;
    logic                                sel_io;
    logic                                dev_ack;

    // reads win when both channels are pending
    assign rd_acc = (state == S_IDLE) && s_axi_arvalid;
    assign wr_acc = (state == S_IDLE) && !s_axi_arvalid && s_axi_awvalid && s_axi_wvalid;

    assign s_axi_arready = rd_acc;
    assign s_axi_awready = wr_acc;
    assign s_axi_wready  = wr_acc;

    assign sel_ram = (addr_q.fld.region == sb2_main_bus_pkg::REGION_WRAM) ||
                     (addr_q.fld.region == sb2_main_bus_pkg::REGION_PALRAM);
    assign sel_io  = (addr_q.fld.region == sb2_main_bus_pkg::REGION_OKI) ||
                     (addr_q.fld.region == sb2_main_bus_pkg::REGION_IO);
    assign dev_ack = ram.ack | io.ack;

    assign ram.req    = (state == S_REQ) && sel_ram;
    assign ram.we     = we_q;
    assign ram.region = addr_q.fld.region;
    assign ram.offset = addr_q.fld.offset;
    assign ram.wdata  = wdata_q;
    assign ram.wstrb  = wstrb_q;

    assign io.req     = (state == S_REQ) && sel_io;
    assign io.we      = we_q;
    assign io.region  = addr_q.fld.region;
    assign io.offset  = addr_q.fld.offset;
    assign io.wdata   = wdata_q;
    assign io.wstrb   = wstrb_q;

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            state        <= S_IDLE;
            s_axi_bvalid <= 1'b0;
            s_axi_rvalid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (rd_acc || wr_acc) state <= S_REQ;
                S_REQ: begin
                    if (sel_ram || sel_io) begin
                        state <= S_WAIT;
                    end else begin
                        // unmapped region answers straight away
                        state        <= S_RESP;
                        s_axi_bvalid <= we_q;
                        s_axi_rvalid <= !we_q;
                    end
                end
                S_WAIT: begin
                    if (dev_ack) begin
                        state        <= S_RESP;
                        s_axi_bvalid <= we_q;
                        s_axi_rvalid <= !we_q;
                    end
                end
                default: begin
                    if ((s_axi_bvalid && s_axi_bready) || (s_axi_rvalid && s_axi_rready)) begin
                        state        <= S_IDLE;
                        s_axi_bvalid <= 1'b0;
                        s_axi_rvalid <= 1'b0;
                    end
                end
            endcase
        end
    end

    // address, write data and response payload
    always_ff @(posedge clk96) begin
        if (rd_acc || wr_acc) begin
            addr_q.raw <= rd_acc ? s_axi_araddr : s_axi_awaddr;
            we_q       <= wr_acc;
            wdata_q    <= s_axi_wdata;
            wstrb_q    <= s_axi_wstrb;
        end
        if (state == S_REQ && !(sel_ram || sel_io)) begin
            rdata_q <= '0;
            resp_q  <= sb2_main_bus_pkg::RESP_DECERR;
        end else if (state == S_WAIT && dev_ack) begin
            rdata_q <= ram.ack ? ram.rdata : io.rdata;
            resp_q  <= sb2_main_bus_pkg::RESP_OKAY;
        end
    end

    assign s_axi_rdata = rdata_q;
    assign s_axi_rresp = resp_q;
    assign s_axi_bresp = resp_q;

endmodule

`default_nettype wire

// ==== sb2_dev_if.sv ====
// request/acknowledge link from the AXI front end to one device group
// host drives the request side, device returns rdata and ack
`timescale 1ns/1ps
`default_nettype none

interface sb2_dev_if;

    logic                                req;     // one-cycle pulse
    logic                                we;
    logic [3:0]                          region;
    logic [sb2_main_bus_pkg::OFFS_W-1:0] offset;
    logic [sb2_main_bus_pkg::DATA_W-1:0] wdata;
    logic [sb2_main_bus_pkg::STRB_W-1:0] wstrb;
    logic [sb2_main_bus_pkg::DATA_W-1:0] rdata;   // valid with ack
    logic                                ack;     // exactly one cycle after req

    modport host (
        output req,
        output we,
        output region,
        output offset,
        output wdata,
        output wstrb,
        input  rdata,
        input  ack
    );

    modport device (
        input  req,
        input  we,
        input  region,
        input  offset,
        input  wdata,
        input  wstrb,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

// ==== sb2_main_bus_pkg.sv ====
// shared widths, address union and region codes for the main bus
// also I/O port offsets, OKI bank bit and AXI response codes
`default_nettype none

package sb2_main_bus_pkg;

    localparam int ADDR_W = 24;  // 68k style 24-bit byte address
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int OFFS_W = 20;  // offset inside a 1 MB region

    // byte address, or region nibble plus offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [3:0]        region;
            logic [OFFS_W-1:0] offset;
        } fld;
    } sb2_addr_u;

    // region codes, top nibble of the address
    localparam logic [3:0] REGION_WRAM   = 4'h1;  // 0x100000
    localparam logic [3:0] REGION_PALRAM = 4'h4;  // 0x400000
    localparam logic [3:0] REGION_OKI    = 4'h5;  // 0x500000 bank latch
    localparam logic [3:0] REGION_IO     = 4'h7;  // 0x700000 cabinet

    // cabinet port byte offsets inside REGION_IO
    localparam logic [OFFS_W-1:0] PORT_JMPR = 20'h00000;
    localparam logic [OFFS_W-1:0] PORT_DSWA = 20'h00004;
    localparam logic [OFFS_W-1:0] PORT_DSWB = 20'h00008;
    localparam logic [OFFS_W-1:0] PORT_IN1  = 20'h0000C;
    localparam logic [OFFS_W-1:0] PORT_IN2  = 20'h00010;
    localparam logic [OFFS_W-1:0] PORT_SYS  = 20'h0001C;

    localparam int OKI_BANK_BIT = 4;  // wdata bit loaded into the bank latch

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

endpackage

`default_nettype wire
